/* source/robPkg.sv */
package robPkg;

    // tag 0 means no tag, live tags are 1..31
    localparam int tagWidth  = 5;
    localparam int robDepth  = 31;
    localparam int nameWidth = 5;
    localparam int dataWidth = 32;
    localparam int regCount  = 32;

    localparam logic [tagWidth-1:0] noTag    = '0;
    localparam logic [tagWidth-1:0] firstTag = 5'd1;
    localparam logic [tagWidth-1:0] lastTag  = 5'd31;

    // only the classes that change retirement
    typedef enum logic [1:0] {
        aluOp,
        loadOp,
        storeOp,
        branchOp
    } opClass;

    typedef struct packed {
        logic                 valid;
        logic [nameWidth-1:0] dest;      // 0 for no destination
        opClass               op;
        logic                 predTaken;
    } issueReq;

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
        logic                 taken;     // resolved direction, branches only
        logic [dataWidth-1:0] target;
    } execResult;

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } loadResult;

    typedef struct packed {
        logic                 valid;
        logic [nameWidth-1:0] name;
        logic [dataWidth-1:0] data;
        logic [tagWidth-1:0]  tag;
    } retireInfo;

    // pointer step, skips the reserved tag
    function automatic logic [tagWidth-1:0] nextTag(input logic [tagWidth-1:0] cur);
        logic [tagWidth-1:0] nxt;
        if (cur == lastTag) begin
            nxt = firstTag;
        end else begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

endpackage

/* source/reorderBuffer.sv */
`timescale 1ns/10ps

module reorderBuffer
    import robPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  issueReq              issue,
    input  execResult            exec,
    input  loadResult            load,
    output logic                 allocValid,
    output logic [tagWidth-1:0]  allocTag,
    output logic                 full,
    output retireInfo            retire,
    output logic                 storeCommit,
    output logic [tagWidth-1:0]  storeTag,
    output logic                 flush,
    output logic [dataWidth-1:0] redirectPc
);

    // per-entry state, indexed directly by tag
    logic [robDepth:1] occupied;
    logic [robDepth:1] complete;
    logic [robDepth:1] isStore;
    logic [robDepth:1] predicted;
    logic [robDepth:1] actual;

    logic [nameWidth-1:0] entryName   [1:robDepth];
    logic [dataWidth-1:0] entryData   [1:robDepth];
    logic [dataWidth-1:0] entryTarget [1:robDepth];

    logic [tagWidth-1:0] head;
    logic [tagWidth-1:0] tail;

    logic canRetire;
    logic mispredict;

    assign full       = &occupied;
    assign allocValid = issue.valid && !full && !flush;  // refused during flush
    assign allocTag   = tail;

    // stores need no writeback to leave
    assign canRetire  = occupied[head] && (complete[head] || isStore[head]);
    assign mispredict = canRetire && !isStore[head] && (predicted[head] != actual[head]);

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied    <= '0;
            complete    <= '0;
            head        <= firstTag;
            tail        <= firstTag;
            retire      <= '0;
            storeCommit <= 1'b0;
            flush       <= 1'b0;
        end else begin
            retire.valid <= 1'b0;
            storeCommit  <= 1'b0;
            flush        <= 1'b0;

            if (allocValid) begin
                occupied[tail] <= 1'b1;
                complete[tail] <= 1'b0;
                tail           <= nextTag(tail);
            end

            // results may arrive in any order
            if (exec.valid) begin
                complete[exec.tag] <= 1'b1;
            end
            if (load.valid) begin
                complete[load.tag] <= 1'b1;
            end

            if (canRetire) begin
                occupied[head] <= 1'b0;
                complete[head] <= 1'b0;
                head           <= nextTag(head);
                if (isStore[head]) begin
                    storeCommit <= 1'b1;
                end else begin
                    retire.valid <= 1'b1;
                    retire.name  <= entryName[head];
                    retire.data  <= entryData[head];
                    retire.tag   <= head;
                end
            end

            // wrong path, drop every younger entry
            if (mispredict) begin
                flush    <= 1'b1;
                occupied <= '0;
                complete <= '0;
                head     <= firstTag;
                tail     <= firstTag;
            end
        end
    end

    // entry payload, only read while the entry is occupied
    always_ff @(posedge clk) begin
        if (allocValid) begin
            entryName[tail] <= issue.dest;
            isStore[tail]   <= (issue.op == storeOp);
            predicted[tail] <= (issue.op == branchOp) && issue.predTaken;
            actual[tail]    <= 1'b0;
        end

        if (exec.valid) begin
            entryData[exec.tag]   <= exec.data;
            actual[exec.tag]      <= exec.taken;
            entryTarget[exec.tag] <= exec.target;
        end

        if (load.valid) begin
            entryData[load.tag] <= load.data;
        end

        if (canRetire && isStore[head]) begin
            storeTag <= head;
        end

        if (mispredict) begin
            redirectPc <= entryTarget[head];
        end
    end

    // the issuing side must watch full
    assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !full)
        else $error("issue presented while full");

    assert property (@(posedge clk) disable iff (rst)
        exec.valid |-> (exec.tag != noTag) && occupied[exec.tag])
        else $error("exec writeback to free tag %0d", exec.tag);

    assert property (@(posedge clk) disable iff (rst)
        load.valid |-> (load.tag != noTag) && occupied[load.tag])
        else $error("load writeback to free tag %0d", load.tag);

    // one retirement per cycle, of one kind
    assert property (@(posedge clk) disable iff (rst)
        !(retire.valid && storeCommit))
        else $error("retire and storeCommit together");

endmodule

/* source/renameTable.sv */
`timescale 1ns/10ps

module renameTable
    import robPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 allocValid,
    input  logic [tagWidth-1:0]  allocTag,
    input  logic [nameWidth-1:0] allocName,
    input  retireInfo            retire,
    input  logic                 flush,
    input  logic [nameWidth-1:0] srcName,
    output logic                 srcBusy,
    output logic [tagWidth-1:0]  srcTag
);

    logic [regCount-1:0] busy;
    logic [tagWidth-1:0] writerTag [0:regCount-1];  // youngest pending writer

    logic releaseHit;

    // an older writer must not free a register a younger one still owns
    assign releaseHit = retire.valid && (writerTag[retire.name] == retire.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (releaseHit) begin
                busy[retire.name] <= 1'b0;
            end
            // later assignment, so a new writer beats the release
            if (allocValid && allocName != '0) begin
                busy[allocName] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocValid) begin
            writerTag[allocName] <= allocTag;
        end
    end

    assign srcBusy = busy[srcName];
    assign srcTag  = srcBusy ? writerTag[srcName] : noTag;

    // the retiring writer is the oldest, its register can't have been freed yet
    assert property (@(posedge clk) disable iff (rst)
        (retire.valid && retire.name != '0) |-> busy[retire.name])
        else $error("retire of x%0d which was not busy", retire.name);

endmodule

/* source/archRegFile.sv */
`timescale 1ns/10ps

module archRegFile
    import robPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  retireInfo            retire,
    input  logic [nameWidth-1:0] srcName,
    output logic [dataWidth-1:0] srcValue
);

    logic [dataWidth-1:0] regs [0:regCount-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.name != '0) begin
            regs[retire.name] <= retire.data;  // x0 writes dropped
        end
    end

    // x0 hardwired
    assign srcValue = (srcName == '0) ? '0 : regs[srcName];

endmodule

/* source/retireUnit.sv */
`timescale 1ns/10ps

module retireUnit
    import robPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  issueReq              issue,
    input  execResult            exec,
    input  loadResult            load,
    input  logic [nameWidth-1:0] srcName,
    output logic                 allocValid,
    output logic [tagWidth-1:0]  allocTag,
    output logic                 full,
    output logic                 srcBusy,
    output logic [tagWidth-1:0]  srcTag,
    output logic [dataWidth-1:0] srcValue,
    output retireInfo            retire,
    output logic                 storeCommit,
    output logic [tagWidth-1:0]  storeTag,
    output logic                 flush,
    output logic [dataWidth-1:0] redirectPc
);

    logic [nameWidth-1:0] allocName;
    logic [dataWidth-1:0] regValue;

    // stores never write a register, keep them out of the rename table
    assign allocName = (issue.op == storeOp) ? '0 : issue.dest;

    reorderBuffer uRob (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .exec        (exec),
        .load        (load),
        .allocValid  (allocValid),
        .allocTag    (allocTag),
        .full        (full),
        .retire      (retire),
        .storeCommit (storeCommit),
        .storeTag    (storeTag),
        .flush       (flush),
        .redirectPc  (redirectPc)
    );

    renameTable uRename (
        .clk        (clk),
        .rst        (rst),
        .allocValid (allocValid),
        .allocTag   (allocTag),
        .allocName  (allocName),
        .retire     (retire),
        .flush      (flush),
        .srcName    (srcName),
        .srcBusy    (srcBusy),
        .srcTag     (srcTag)
    );

    archRegFile uRegs (
        .clk      (clk),
        .rst      (rst),
        .retire   (retire),
        .srcName  (srcName),
        .srcValue (regValue)
    );

    assign srcValue = srcBusy ? '0 : regValue;  // pending operand shows tag only

endmodule

/* sim/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // reset held for 8 rising edges
    initial begin
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* sim/robTb.sv */
`timescale 1ns/10ps

module robTb
    import robPkg::*;
();

    logic                 clk;
    logic                 rst;
    issueReq              issue;
    execResult            exec;
    loadResult            load;
    logic [nameWidth-1:0] srcName;
    logic                 allocValid;
    logic [tagWidth-1:0]  allocTag;
    logic                 full;
    logic                 srcBusy;
    logic [tagWidth-1:0]  srcTag;
    logic [dataWidth-1:0] srcValue;
    retireInfo            retire;
    logic                 storeCommit;
    logic [tagWidth-1:0]  storeTag;
    logic                 flush;
    logic [dataWidth-1:0] redirectPc;

    string toks[$];  // all data fields, 29 per row
    int    rowCount   = 0;
    int    cycleLimit = 0;
    int    cycles     = 0;
    int    passCount  = 0;
    int    failCount  = 0;
    int    testFails  = 0;
    logic  loadOk;

    clockGen clkGen (.clk(clk), .rst(rst));

    retireUnit u_dut (
        .clk(clk), .rst(rst), .issue(issue), .exec(exec), .load(load), .srcName(srcName),
        .allocValid(allocValid), .allocTag(allocTag), .full(full), .srcBusy(srcBusy),
        .srcTag(srcTag), .srcValue(srcValue), .retire(retire), .storeCommit(storeCommit),
        .storeTag(storeTag), .flush(flush), .redirectPc(redirectPc)
    );

    function automatic void splitLine(input string line);
        int         start;
        logic [7:0] c;
        start = -1;
        for (int i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line.getc(i) : 8'h20;
            if (c <= 8'h20) begin  // blanks and line ends
                if (start >= 0) begin
                    toks.push_back(line.substr(start, i - 1));
                end
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endfunction

    function automatic string tokenAt(input int r, input int col);
        return toks[r * 29 + col];
    endfunction

    function automatic logic [31:0] field(input int r, input int col);
        string s;
        s = tokenAt(r, col);
        return s.atohex();
    endfunction

    task automatic readData();
        int    fd;
        int    n;
        string line;
        fd = $fopen("sim/robInput.txt", "r");
        loadOk = 1'b0;
        if (fd == 0) begin
            $display("could not open the stimulus file sim/robInput.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != 8'h23) begin  // skip # lines
                    splitLine(line);
                end
            end
            $fclose(fd);
            loadOk = (toks.size() > 0) && (toks.size() % 29 == 0);
            if (!loadOk) begin
                $display("stimulus file is empty or has a row with the wrong field count");
            end
        end
        if (loadOk) begin
            rowCount = toks.size() / 29;
            for (int r = 0; r < rowCount; r++) begin
                cycleLimit += field(r, 1);
            end
            cycleLimit += 8 + 50;  // reset, then slack
        end
    endtask

    task automatic applyRow(input int r);
        issue.valid     <= 1'(field(r, 2));
        issue.dest      <= nameWidth'(field(r, 3));
        issue.op        <= opClass'(2'(field(r, 4)));
        issue.predTaken <= 1'(field(r, 5));
        exec.valid      <= 1'(field(r, 6));
        exec.tag        <= tagWidth'(field(r, 7));
        exec.data       <= field(r, 8);
        exec.taken      <= 1'(field(r, 9));
        exec.target     <= field(r, 10);
        load.valid      <= 1'(field(r, 11));
        load.tag        <= tagWidth'(field(r, 12));
        load.data       <= field(r, 13);
        srcName         <= nameWidth'(field(r, 14));
    endtask

    task automatic checkField(input int r, input int col, input string name,
                              input logic [31:0] got);
        string       tok;
        logic [31:0] want;
        tok = tokenAt(r, col);
        if (tok != "x") begin
            want = tok.atohex();
            assert (got === want) passCount++;
            else begin
                $display("Fail at %0t: %s expected %h got %h", $time, name, want, got);
                failCount++;
                testFails++;
            end
        end
    endtask

    task automatic checkRow(input int r);
        checkField(r, 15, "allocValid", 32'(allocValid));
        checkField(r, 16, "allocTag", 32'(allocTag));
        checkField(r, 17, "full", 32'(full));
        checkField(r, 18, "srcBusy", 32'(srcBusy));
        checkField(r, 19, "srcTag", 32'(srcTag));
        checkField(r, 20, "srcValue", srcValue);
        checkField(r, 21, "retire.valid", 32'(retire.valid));
        checkField(r, 22, "retire.name", 32'(retire.name));
        checkField(r, 23, "retire.data", retire.data);
        checkField(r, 24, "retire.tag", 32'(retire.tag));
        checkField(r, 25, "storeCommit", 32'(storeCommit));
        checkField(r, 26, "storeTag", 32'(storeTag));
        checkField(r, 27, "flush", 32'(flush));
        checkField(r, 28, "redirectPc", redirectPc);
    endtask

    task automatic runRows();
        int reps;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        for (int r = 0; r < rowCount; r++) begin
            reps = field(r, 1);
            for (int k = 0; k < reps; k++) begin
                applyRow(r);
                @(negedge clk);  // mid-cycle, outputs settled
                checkRow(r);
                @(posedge clk);
            end
            if (r == rowCount - 1 || tokenAt(r + 1, 0) != tokenAt(r, 0)) begin
                if (testFails == 0) begin
                    $display("test %s passed", tokenAt(r, 0));
                end else begin
                    $display("test %s failed with %0d errors", tokenAt(r, 0), testFails);
                end
                testFails = 0;
            end
        end
    endtask

    initial begin
        issue   <= '0;
        exec    <= '0;
        load    <= '0;
        srcName <= '0;
        readData();
        if (!loadOk) begin
            $display("Errors found");
        end else begin
            runRows();
            $display("checks passed %0d, checks failed %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("run exceeded its cycle limit of %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

/* sim/robInput.txt */
# test rep | issue: valid dest op(0 alu 1 load 2 store 3 branch) predTaken | exec: valid tag data taken target | load: valid tag data | srcName
# expected: allocValid allocTag full srcBusy srcTag srcValue retValid retName retData retTag storeCommit storeTag flush redirectPc (x = not checked)
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 x 0 0 0 0 0 x x x 0 x 0 x
1 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 x 0 0 0 0 0 x x x 0 x 0 x
1 1 0 0 0 0 0 0 0 0 0 0 0 0 1f 0 x 0 0 0 0 0 x x x 0 x 0 x
2 1 1 1 0 0 0 0 0 0 0 0 0 0 0 1 1 0 x x x 0 x x x 0 x 0 x
2 1 1 2 0 0 0 0 0 0 0 0 0 0 0 1 2 0 x x x 0 x x x 0 x 0 x
2 1 1 3 0 0 0 0 0 0 0 0 0 0 0 1 3 0 x x x 0 x x x 0 x 0 x
2 1 0 0 0 0 1 3 33 0 0 0 0 0 3 0 x 0 1 3 0 0 x x x 0 x 0 x
2 1 0 0 0 0 1 1 11 0 0 0 0 0 1 0 x 0 1 1 0 0 x x x 0 x 0 x
2 1 0 0 0 0 1 2 22 0 0 0 0 0 2 0 x 0 1 2 0 0 x x x 0 x 0 x
2 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 x 0 1 1 0 1 1 11 1 0 x 0 x
2 1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 x 0 0 0 11 1 2 22 2 0 x 0 x
2 1 0 0 0 0 0 0 0 0 0 0 0 0 2 0 x 0 0 0 22 1 3 33 3 0 x 0 x
2 1 0 0 0 0 0 0 0 0 0 0 0 0 3 0 x 0 0 0 33 0 x x x 0 x 0 x
3 1 1 5 0 0 0 0 0 0 0 0 0 0 5 1 4 0 0 0 0 0 x x x 0 x 0 x
3 1 1 5 0 0 0 0 0 0 0 0 0 0 5 1 5 0 1 4 0 0 x x x 0 x 0 x
3 1 0 0 0 0 1 4 44 0 0 0 0 0 5 0 x 0 1 5 0 0 x x x 0 x 0 x
3 1 0 0 0 0 1 5 55 0 0 0 0 0 5 0 x 0 1 5 0 0 x x x 0 x 0 x
3 1 0 0 0 0 0 0 0 0 0 0 0 0 5 0 x 0 1 5 0 1 5 44 4 0 x 0 x
3 1 0 0 0 0 0 0 0 0 0 0 0 0 5 0 x 0 1 5 0 1 5 55 5 0 x 0 x
3 1 0 0 0 0 0 0 0 0 0 0 0 0 5 0 x 0 0 0 55 0 x x x 0 x 0 x
4 1 1 0 2 0 0 0 0 0 0 0 0 0 6 1 6 0 0 0 0 0 x x x 0 x 0 x
4 1 1 6 1 0 0 0 0 0 0 0 0 0 6 1 7 0 0 0 0 0 x x x 0 x 0 x
4 1 0 0 0 0 0 0 0 0 0 1 7 77 6 0 x 0 1 7 0 0 x x x 1 6 0 x
4 1 0 0 0 0 0 0 0 0 0 0 0 0 6 0 x 0 1 7 0 0 x x x 0 x 0 x
4 1 0 0 0 0 0 0 0 0 0 0 0 0 6 0 x 0 1 7 0 1 6 77 7 0 x 0 x
4 1 0 0 0 0 0 0 0 0 0 0 0 0 6 0 x 0 0 0 77 0 x x x 0 x 0 x
5 1 1 0 3 0 0 0 0 0 0 0 0 0 0 1 8 0 x x x 0 x x x 0 x 0 x
5 1 1 7 0 0 0 0 0 0 0 0 0 0 7 1 9 0 0 0 0 0 x x x 0 x 0 x
5 1 1 8 0 0 1 9 99 0 0 0 0 0 7 1 a 0 1 9 0 0 x x x 0 x 0 x
5 1 0 0 0 0 1 8 0 1 1000 0 0 0 8 0 x 0 1 a 0 0 x x x 0 x 0 x
5 1 0 0 0 0 1 a aa 0 0 0 0 0 7 0 x 0 1 9 0 0 x x x 0 x 0 x
5 1 1 9 0 0 0 0 0 0 0 0 0 0 7 0 x 0 1 9 0 1 0 0 8 0 x 1 1000
5 1 1 a 0 0 0 0 0 0 0 0 0 0 7 1 1 0 0 0 0 0 x x x 0 x 0 x
5 1 0 0 0 0 0 0 0 0 0 0 0 0 8 0 x 0 0 0 0 0 x x x 0 x 0 x
6 1e 1 0 0 0 0 0 0 0 0 0 0 0 0 1 x 0 x x x 0 x x x 0 x 0 x
6 1 0 0 0 0 1 1 abcd 0 0 0 0 0 a 0 x 1 1 1 0 0 x x x 0 x 0 x
6 1 0 0 0 0 0 0 0 0 0 0 0 0 a 0 x 1 1 1 0 0 x x x 0 x 0 x
6 1 1 0 0 0 0 0 0 0 0 0 0 0 a 1 1 0 1 1 0 1 a abcd 1 0 x 0 x
6 1 0 0 0 0 0 0 0 0 0 0 0 0 a 0 x 1 0 0 abcd 0 x x x 0 x 0 x

/* src.f */
source/robPkg.sv
source/reorderBuffer.sv
source/renameTable.sv
source/archRegFile.sv
source/retireUnit.sv
sim/clockGen.sv
sim/robTb.sv

/* run.sh */
#!/bin/sh
# build and run the retirement unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module robTb -f src.f -o robSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/robSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line
if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "testbench reported failures, see sim.log"
exit 1
